// File: rv_isa_pkg.sv
// rv64i encodings and instruction field types, imported by every decode-stage module
package rv_isa_pkg;

  localparam int XLEN   = 64;  // data and pc width
  localparam int ILEN   = 32;
  localparam int GPR_AW = 5;

  typedef logic [GPR_AW-1:0] gpr_addr_t;
  typedef logic [XLEN-1:0]   xword_t;
  typedef logic [ILEN-1:0]   inst_t;

  localparam inst_t NOP_INST = 32'h0000_0013;  // addi x0, x0, 0

  // opcode groups this decoder knows about
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_OP     = 7'b0110011,
    OP_IMM_32 = 7'b0011011,
    OP_32     = 7'b0111011
  } opcode_e;

  // branch funct3
  localparam logic [2:0] BEQ  = 3'b000;
  localparam logic [2:0] BNE  = 3'b001;
  localparam logic [2:0] BLT  = 3'b100;
  localparam logic [2:0] BGE  = 3'b101;
  localparam logic [2:0] BLTU = 3'b110;
  localparam logic [2:0] BGEU = 3'b111;

  // alu funct3 for OP / OP-IMM groups
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;  // srl / sra
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  localparam logic [6:0] F7_ALT = 7'b0100000;  // sub, sra

  // r-type layout, other formats reuse the same bit positions
  typedef struct packed {
    logic [6:0] funct7;
    gpr_addr_t  rs2;
    gpr_addr_t  rs1;
    logic [2:0] funct3;
    gpr_addr_t  rd;
    logic [6:0] opcode;
  } inst_fields_t;

endpackage

// File: id_pipe_pkg.sv
// bus structs between pipeline stages and the decoded control word, shared by the id stage
package id_pipe_pkg;

  import rv_isa_pkg::*;

  typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B  // lui
  } alu_op_e;

  typedef enum logic [1:0] {
    SRC2_RS2  = 2'd0,
    SRC2_IMM  = 2'd1,
    SRC2_FOUR = 2'd2   // link address pc+4
  } src2_sel_e;

  localparam logic SRC1_PC = 1'b1;  // 0 selects rs1

  typedef struct packed {
    logic       alu_src1_sel;
    src2_sel_e  alu_src2_sel;
    logic       word_cut;      // *W ops, result cut to 32 bits
    alu_op_e    alu_op;
    logic       gpr_wen;
    logic       mem_ren;
    logic       mem_wen;
    logic [2:0] mem_op;        // load/store funct3
    logic       load_sel;
    logic       br_en;
    logic       jmp_en;
    logic       jalr_sel;
    logic       invalid;
  } ctrl_t;

  typedef struct packed {
    inst_t  inst;
    xword_t pc;
  } fs_to_ds_t;

  typedef struct packed {
    ctrl_t     ctrl;
    xword_t    rs1data;
    xword_t    rs2data;
    xword_t    imm;
    xword_t    pc;
    gpr_addr_t rd;
  } ds_to_es_t;

  typedef struct packed {
    logic   taken;
    xword_t target;
  } br_t;

  typedef struct packed {
    logic      wen;
    gpr_addr_t addr;
    xword_t    data;
  } wb_t;

  // valid is separate so rd 0 can mean a real (discarded) x0 write
  typedef struct packed {
    logic      valid;
    gpr_addr_t rd;
    xword_t    result;
  } bypass_t;

endpackage

// File: ds_latch.sv
// fetch-to-decode pipeline register with valid/allowin handshake, instantiated by id_stage
`timescale 1ns/1ps

module ds_latch import rv_isa_pkg::*, id_pipe_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst_n,
  // from fetch
  input  logic      i_fs_valid,
  input  fs_to_ds_t i_fs_bus,
  output logic      o_ds_allowin,
  // stage control
  input  logic      i_ready_go,
  input  logic      i_es_allowin,
  input  logic      i_br_taken,
  // to decode logic
  output logic      o_ds_valid,
  output fs_to_ds_t o_ds_bus
);

  logic      ds_valid_q;
  fs_to_ds_t ds_bus_q;
  logic      capture;

  assign o_ds_allowin = ~ds_valid_q | (i_ready_go & i_es_allowin);
  assign capture      = i_fs_valid & o_ds_allowin;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ds_valid_q <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid_q <= i_fs_valid;
    end
  end

  // the fetched inst is on the wrong path when a branch leaves this cycle
  always_ff @(posedge i_clk) begin
    if (capture) begin
      ds_bus_q.pc   <= i_fs_bus.pc;
      ds_bus_q.inst <= i_br_taken ? NOP_INST : i_fs_bus.inst;
    end
  end

  assign o_ds_valid = ds_valid_q;
  assign o_ds_bus   = ds_bus_q;

endmodule

// File: inst_decoder.sv
// rv64i decoder producing register indices, immediate and control word for id_stage
`timescale 1ns/1ps

module inst_decoder import rv_isa_pkg::*, id_pipe_pkg::*; #(
  parameter int NUM_GPR = 32
) (
  input  inst_t     i_inst,
  output gpr_addr_t o_rs1,
  output gpr_addr_t o_rs2,
  output gpr_addr_t o_rd,
  output xword_t    o_imm,
  output ctrl_t     o_ctrl
);

  inst_fields_t f;
  xword_t       imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [6:0]   shift_hi;
  logic         use_rs1, use_rs2, use_rd, bad;
  ctrl_t        c;

  function automatic alu_op_e alu_sel(logic [2:0] f3, logic alt);
    case (f3)
      F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
      F3_SLL:  return ALU_SLL;
      F3_SLT:  return ALU_SLT;
      F3_SLTU: return ALU_SLTU;
      F3_XOR:  return ALU_XOR;
      F3_SR:   return alt ? ALU_SRA : ALU_SRL;
      F3_OR:   return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign f = inst_fields_t'(i_inst);

  assign imm_i = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_u = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'h000};
  assign imm_j = {{(XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  always_comb begin
    case (f.opcode)
      OP_STORE:         o_imm = imm_s;
      OP_BRANCH:        o_imm = imm_b;
      OP_LUI, OP_AUIPC: o_imm = imm_u;
      OP_JAL:           o_imm = imm_j;
      default:          o_imm = imm_i;
    endcase
  end

  // shamt is 6 bits on rv64, 5 bits on the *W forms
  assign shift_hi = (f.opcode == OP_IMM_32) ? f.funct7 : {f.funct7[6:1], 1'b0};

  always_comb begin
    c       = '0;
    use_rs1 = 1'b1;
    use_rs2 = 1'b0;
    use_rd  = 1'b1;
    bad     = 1'b0;
    case (f.opcode)
      OP_LUI: begin
        use_rs1         = 1'b0;
        c.alu_src2_sel  = SRC2_IMM;
        c.alu_op        = ALU_PASS_B;
        c.gpr_wen       = 1'b1;
      end
      OP_AUIPC: begin
        use_rs1         = 1'b0;
        c.alu_src1_sel  = SRC1_PC;
        c.alu_src2_sel  = SRC2_IMM;
        c.gpr_wen       = 1'b1;
      end
      OP_JAL, OP_JALR: begin
        use_rs1         = (f.opcode == OP_JALR);
        c.alu_src1_sel  = SRC1_PC;
        c.alu_src2_sel  = SRC2_FOUR;
        c.gpr_wen       = 1'b1;
        c.jmp_en        = 1'b1;
        c.jalr_sel      = (f.opcode == OP_JALR);
        bad             = c.jalr_sel && (f.funct3 != 3'b000);
      end
      OP_BRANCH: begin
        use_rs2 = 1'b1;
        use_rd  = 1'b0;
        c.br_en = 1'b1;
        bad     = (f.funct3[2:1] == 2'b01);
      end
      OP_LOAD: begin
        c.alu_src2_sel  = SRC2_IMM;
        c.gpr_wen       = 1'b1;
        c.mem_ren       = 1'b1;
        c.load_sel      = 1'b1;
        c.mem_op        = f.funct3;
        bad             = (f.funct3 == 3'b111);
      end
      OP_STORE: begin
        use_rs2         = 1'b1;
        use_rd          = 1'b0;
        c.alu_src2_sel  = SRC2_IMM;
        c.mem_wen       = 1'b1;
        c.mem_op        = f.funct3;
        bad             = f.funct3[2];  // sb..sd only
      end
      OP_IMM, OP_IMM_32: begin
        c.alu_src2_sel  = SRC2_IMM;
        c.word_cut      = (f.opcode == OP_IMM_32);
        c.gpr_wen       = 1'b1;
        c.alu_op        = alu_sel(f.funct3, (f.funct3 == F3_SR) && f.funct7[5]);
        if (f.funct3 == F3_SLL || f.funct3 == F3_SR) begin
          bad = (shift_hi != 7'h00) && !(shift_hi == F7_ALT && f.funct3 == F3_SR);
        end else begin
          bad = c.word_cut && (f.funct3 != F3_ADD);
        end
      end
      OP_OP, OP_32: begin
        use_rs2    = 1'b1;
        c.word_cut = (f.opcode == OP_32);
        c.gpr_wen  = 1'b1;
        c.alu_op   = alu_sel(f.funct3, f.funct7[5]);
        bad        = (f.funct7 != 7'h00) &&
                     !(f.funct7 == F7_ALT && (f.funct3 == F3_ADD || f.funct3 == F3_SR));
        if (c.word_cut && !(f.funct3 inside {F3_ADD, F3_SLL, F3_SR})) begin
          bad = 1'b1;
        end
      end
      default: bad = 1'b1;
    endcase
    // writes to x0 are dropped, so the nop writes nothing
    if (f.rd == '0) begin
      c.gpr_wen = 1'b0;
    end
    // rv64e has only 16 registers
    if ((use_rs1 && int'(f.rs1) >= NUM_GPR) || (use_rs2 && int'(f.rs2) >= NUM_GPR) ||
        (use_rd && int'(f.rd) >= NUM_GPR)) begin
      bad = 1'b1;
    end
    if (bad) begin
      c         = '0;
      c.invalid = 1'b1;
    end
  end

  // unused fields read as x0 so they never match a bypass or cause a stall
  assign o_rs1  = use_rs1 ? f.rs1 : '0;
  assign o_rs2  = use_rs2 ? f.rs2 : '0;
  assign o_rd   = use_rd ? f.rd : '0;
  assign o_ctrl = c;

endmodule

// File: gpr_file.sv
// general register file, two async read ports and one write port fed by write-back
`timescale 1ns/1ps

module gpr_file import rv_isa_pkg::*, id_pipe_pkg::*; #(
  parameter int NUM_GPR = 32
) (
  input  logic      i_clk,
  input  gpr_addr_t i_raddr1,
  input  gpr_addr_t i_raddr2,
  output xword_t    o_rdata1,
  output xword_t    o_rdata2,
  input  wb_t       i_wb
);

  localparam int AW = $clog2(NUM_GPR);

  xword_t regs [NUM_GPR];
  logic   wr_ok;
  logic   rd1_zero, rd2_zero;

  assign wr_ok = i_wb.wen && (i_wb.addr != '0) && (int'(i_wb.addr) < NUM_GPR);

  always_ff @(posedge i_clk) begin
    if (wr_ok) begin
      regs[i_wb.addr[AW-1:0]] <= i_wb.data;
    end
  end

  // x0 and out-of-range indices read zero, entry 0 is never written
  assign rd1_zero = (i_raddr1 == '0) || (int'(i_raddr1) >= NUM_GPR);
  assign rd2_zero = (i_raddr2 == '0) || (int'(i_raddr2) >= NUM_GPR);

  assign o_rdata1 = rd1_zero ? '0 : regs[i_raddr1[AW-1:0]];
  assign o_rdata2 = rd2_zero ? '0 : regs[i_raddr2[AW-1:0]];

endmodule

// File: operand_bypass.sv
// operand forwarding from execute, memory and write-back, plus the stall decision for id_stage
`timescale 1ns/1ps

module operand_bypass import rv_isa_pkg::*, id_pipe_pkg::*; (
  input  logic      i_ds_valid,
  input  gpr_addr_t i_rs1,
  input  gpr_addr_t i_rs2,
  input  xword_t    i_rf_rdata1,
  input  xword_t    i_rf_rdata2,
  input  bypass_t   i_es_bp,
  input  bypass_t   i_ms_bp,
  input  bypass_t   i_wb_bp,
  input  logic      i_es_load,        // inst in execute is a load
  input  logic      i_ms_data_stall,  // memory result not back yet
  output xword_t    o_rs1data,
  output xword_t    o_rs2data,
  output logic      o_ready_go
);

  logic es_hit1, es_hit2;
  logic ms_hit1, ms_hit2;
  logic wb_hit1, wb_hit2;
  logic ms_sel;
  logic load_use, ms_stall;

  function automatic logic bp_hit(bypass_t bp, gpr_addr_t rs);
    return bp.valid && (bp.rd != '0) && (bp.rd == rs);
  endfunction

  assign es_hit1 = bp_hit(i_es_bp, i_rs1);
  assign es_hit2 = bp_hit(i_es_bp, i_rs2);
  assign ms_hit1 = bp_hit(i_ms_bp, i_rs1);
  assign ms_hit2 = bp_hit(i_ms_bp, i_rs2);
  assign wb_hit1 = bp_hit(i_wb_bp, i_rs1);
  assign wb_hit2 = bp_hit(i_wb_bp, i_rs2);

  // youngest producer wins
  assign o_rs1data = es_hit1 ? i_es_bp.result :
                     ms_hit1 ? i_ms_bp.result :
                     wb_hit1 ? i_wb_bp.result :
                               i_rf_rdata1;

  assign o_rs2data = es_hit2 ? i_es_bp.result :
                     ms_hit2 ? i_ms_bp.result :
                     wb_hit2 ? i_wb_bp.result :
                               i_rf_rdata2;

  // memory stage only counts when execute does not shadow it
  assign ms_sel = (ms_hit1 & ~es_hit1) | (ms_hit2 & ~es_hit2);

  // load data is not available until the load reaches memory
  assign load_use = i_es_load & (es_hit1 | es_hit2);
  assign ms_stall = i_ms_data_stall & ms_sel;

  assign o_ready_go = ~(i_ds_valid & (load_use | ms_stall));

endmodule

// File: branch_unit.sv
// branch condition and jump/branch target for id_stage, result goes back to fetch
`timescale 1ns/1ps

module branch_unit import rv_isa_pkg::*, id_pipe_pkg::*; (
  input  logic       i_fire,      // stage hands the inst to execute this cycle
  input  ctrl_t      i_ctrl,
  input  xword_t     i_pc,
  input  xword_t     i_imm,
  input  xword_t     i_rs1data,
  input  xword_t     i_rs2data,
  input  logic [2:0] i_funct3,
  output br_t        o_br
);

  logic   eq, lt, ltu;
  logic   cond;
  xword_t base;
  xword_t sum;

  assign eq  = (i_rs1data == i_rs2data);
  assign lt  = ($signed(i_rs1data) < $signed(i_rs2data));
  assign ltu = (i_rs1data < i_rs2data);

  always_comb begin
    case (i_funct3)
      BEQ:     cond = eq;
      BNE:     cond = ~eq;
      BLT:     cond = lt;
      BGE:     cond = ~lt;
      BLTU:    cond = ltu;
      BGEU:    cond = ~ltu;
      default: cond = 1'b0;
    endcase
  end

  assign base = i_ctrl.jalr_sel ? i_rs1data : i_pc;
  assign sum  = base + i_imm;

  assign o_br.target = {sum[XLEN-1:1], sum[0] & ~i_ctrl.jalr_sel};  // jalr clears bit 0
  assign o_br.taken  = i_fire & (i_ctrl.jmp_en | (i_ctrl.br_en & cond));

endmodule

// File: id_stage.sv
// rv64i decode stage top, between fetch and execute; holds no logic of its own beyond wiring
`timescale 1ns/1ps

module id_stage import rv_isa_pkg::*, id_pipe_pkg::*; #(
  parameter int NUM_GPR = 32
) (
  input  logic      i_clk,
  input  logic      i_rst_n,
  // fetch side
  input  logic      i_fs_valid,
  input  fs_to_ds_t i_fs_bus,
  output logic      o_ds_allowin,
  // execute side
  input  logic      i_es_allowin,
  output logic      o_ds_to_es_valid,
  output ds_to_es_t o_ds_to_es_bus,
  output br_t       o_br_bus,           // to fetch
  // write-back and forwarding
  input  wb_t       i_wb,
  input  bypass_t   i_es_bp,
  input  bypass_t   i_ms_bp,
  input  bypass_t   i_wb_bp,
  input  logic      i_es_load,
  input  logic      i_ms_data_stall
);

  logic      ds_valid;
  logic      ready_go;
  fs_to_ds_t ds_bus;
  gpr_addr_t rs1, rs2, rd;
  xword_t    imm;
  ctrl_t     ctrl;
  xword_t    rf_rdata1, rf_rdata2;
  xword_t    rs1data, rs2data;

  assign o_ds_to_es_valid = ds_valid & ready_go;

  ds_latch u_latch (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_fs_valid   (i_fs_valid),
    .i_fs_bus     (i_fs_bus),
    .o_ds_allowin (o_ds_allowin),
    .i_ready_go   (ready_go),
    .i_es_allowin (i_es_allowin),
    .i_br_taken   (o_br_bus.taken),
    .o_ds_valid   (ds_valid),
    .o_ds_bus     (ds_bus)
  );

  inst_decoder #(.NUM_GPR(NUM_GPR)) u_dec (
    .i_inst (ds_bus.inst),
    .o_rs1  (rs1),
    .o_rs2  (rs2),
    .o_rd   (rd),
    .o_imm  (imm),
    .o_ctrl (ctrl)
  );

  gpr_file #(.NUM_GPR(NUM_GPR)) u_gpr (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .o_rdata1 (rf_rdata1),
    .o_rdata2 (rf_rdata2),
    .i_wb     (i_wb)
  );

  operand_bypass u_bypass (
    .i_ds_valid      (ds_valid),
    .i_rs1           (rs1),
    .i_rs2           (rs2),
    .i_rf_rdata1     (rf_rdata1),
    .i_rf_rdata2     (rf_rdata2),
    .i_es_bp         (i_es_bp),
    .i_ms_bp         (i_ms_bp),
    .i_wb_bp         (i_wb_bp),
    .i_es_load       (i_es_load),
    .i_ms_data_stall (i_ms_data_stall),
    .o_rs1data       (rs1data),
    .o_rs2data       (rs2data),
    .o_ready_go      (ready_go)
  );

  branch_unit u_bru (
    .i_fire    (o_ds_to_es_valid),
    .i_ctrl    (ctrl),
    .i_pc      (ds_bus.pc),
    .i_imm     (imm),
    .i_rs1data (rs1data),
    .i_rs2data (rs2data),
    .i_funct3  (ds_bus.inst[14:12]),
    .o_br      (o_br_bus)
  );

  assign o_ds_to_es_bus = '{ctrl: ctrl, rs1data: rs1data, rs2data: rs2data,
                            imm: imm, pc: ds_bus.pc, rd: rd};

endmodule

// File: id_stage_model.svh
// testbench reference functions for the decode stage, include inside a module importing both packages
`ifndef ID_STAGE_MODEL_SVH
`define ID_STAGE_MODEL_SVH

// immediate by opcode, i-type when nothing else applies
function automatic xword_t model_imm(inst_t inst);
  case (inst[6:0])
    OP_STORE:         return {{(XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    OP_BRANCH:        return {{(XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    OP_LUI, OP_AUIPC: return {{(XLEN-32){inst[31]}}, inst[31:12], 12'h000};
    OP_JAL:           return {{(XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    default:          return {{(XLEN-12){inst[31]}}, inst[31:20]};
  endcase
endfunction

function automatic logic model_br_cond(logic [2:0] f3, xword_t a, xword_t b);
  case (f3)
    BEQ:     return a == b;
    BNE:     return a != b;
    BLT:     return $signed(a) < $signed(b);
    BGE:     return $signed(a) >= $signed(b);
    BLTU:    return a < b;
    BGEU:    return a >= b;
    default: return 1'b0;
  endcase
endfunction

function automatic xword_t model_target(xword_t pc, xword_t imm, xword_t rs1, logic jalr);
  xword_t t;
  t = jalr ? (rs1 + imm) : (pc + imm);
  if (jalr) t[0] = 1'b0;
  return t;
endfunction

// execute over memory over write-back over register file, x0 never forwarded
function automatic xword_t model_fwd(gpr_addr_t rs, xword_t rf, bypass_t es, bypass_t ms,
                                     bypass_t wb);
  if (rs == '0) return rf;
  if (es.valid && es.rd == rs) return es.result;
  if (ms.valid && ms.rd == rs) return ms.result;
  if (wb.valid && wb.rd == rs) return wb.result;
  return rf;
endfunction

// inst that the latch holds after a capture
function automatic inst_t model_latched(logic br_taken, inst_t fetched);
  return br_taken ? NOP_INST : fetched;
endfunction

`endif

// File: tb_id_stage.sv
// testbench for id_stage, runs random decode, forwarding, stall, branch and handshake checks
`timescale 1ns/1ps

module tb_id_stage import rv_isa_pkg::*, id_pipe_pkg::*; ();

  `include "id_stage_model.svh"

  localparam int N_ITER      = 40;
  localparam int N_TESTS     = 6;
  localparam int RST_CYC     = 16;
  localparam int TIMEOUT_CYC = N_TESTS * N_ITER * 20 + RST_CYC;

  localparam logic [6:0] ALU_GROUPS [4] = '{OP_OP, OP_IMM, OP_32, OP_IMM_32};
  // alu op per funct3 when funct7 bit 5 is clear
  localparam alu_op_e OP_TAB [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
                                     ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};

  logic      clk = 1'b0;
  logic      rst_n;
  logic      fs_valid;
  fs_to_ds_t fs_bus;
  logic      es_allowin;
  wb_t       wb;
  bypass_t   es_bp, ms_bp, wb_bp;
  logic      es_load;
  logic      ms_data_stall;
  logic      ds_allowin;
  logic      ds_to_es_valid;
  ds_to_es_t ds_out;
  br_t       br_bus;

  xword_t shadow [32];  // expected register contents
  int     n_checks, n_errors, n_tests, n_bad_tests;

  id_stage #(.NUM_GPR(32)) dut0 (
    .i_clk            (clk),
    .i_rst_n          (rst_n),
    .i_fs_valid       (fs_valid),
    .i_fs_bus         (fs_bus),
    .o_ds_allowin     (ds_allowin),
    .i_es_allowin     (es_allowin),
    .o_ds_to_es_valid (ds_to_es_valid),
    .o_ds_to_es_bus   (ds_out),
    .o_br_bus         (br_bus),
    .i_wb             (wb),
    .i_es_bp          (es_bp),
    .i_ms_bp          (ms_bp),
    .i_wb_bp          (wb_bp),
    .i_es_load        (es_load),
    .i_ms_data_stall  (ms_data_stall)
  );

  always #50 clk = ~clk;

  task automatic check(input string what, input logic [319:0] got, input logic [319:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERROR at %0t: %s mismatch, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    n_tests++;
    if (n_errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      n_bad_tests++;
      $display("test %s: %0d mismatches", name, n_errors - errs_before);
    end
  endtask

  function automatic xword_t rand_word();
    return {$urandom(), $urandom()};
  endfunction

  function automatic xword_t rand_pc();
    xword_t w;
    w      = rand_word();
    w[1:0] = 2'b00;
    return w;
  endfunction

  function automatic gpr_addr_t rand_reg();
    return gpr_addr_t'($urandom_range(31, 1));
  endfunction

  function automatic bypass_t rand_bp();
    bypass_t b;
    b.valid  = ($urandom_range(3, 0) != 0);
    b.rd     = gpr_addr_t'($urandom_range(3, 0));  // small range so sources collide
    b.result = rand_word();
    return b;
  endfunction

  // random legal op / op-imm / op-32 / op-imm-32 instruction and its alu op
  task automatic make_alu(input logic [6:0] opc, input gpr_addr_t rs1, input gpr_addr_t rs2,
                          input gpr_addr_t rd, output inst_t inst, output alu_op_e op);
    logic [31:0] r;
    logic [2:0]  f3;
    logic        word, reg_op, alt;
    r      = $urandom();
    word   = (opc == OP_32) || (opc == OP_IMM_32);
    reg_op = (opc == OP_OP) || (opc == OP_32);
    f3     = r[2:0];
    if (word) begin
      f3 = (r[1:0] == 2'd0) ? F3_ADD : (r[1:0] == 2'd1) ? F3_SLL : F3_SR;
    end
    alt = r[3] && ((f3 == F3_SR) || (reg_op && f3 == F3_ADD));
    op  = OP_TAB[f3];
    if (alt) op = (f3 == F3_ADD) ? ALU_SUB : ALU_SRA;
    if (reg_op) begin
      inst = {alt ? F7_ALT : 7'h00, rs2, rs1, f3, rd, opc};
    end else if (f3 == F3_SLL || f3 == F3_SR) begin
      inst = {1'b0, alt, 4'b0000, word ? 1'b0 : r[9], r[8:4], rs1, f3, rd, opc};  // shamt
    end else begin
      inst = {r[31:20], rs1, f3, rd, opc};
    end
  endtask

  // offer one instruction to the stage, returns on the edge that captures it
  task automatic send(input inst_t inst, input xword_t pc);
    @(posedge clk);
    fs_valid <= 1'b1;
    fs_bus   <= '{inst: inst, pc: pc};
    @(negedge clk);
    while (!ds_allowin) @(negedge clk);
    @(posedge clk);
    fs_valid <= 1'b0;
  endtask

  initial begin : main
    int        e0, kind, hold;
    gpr_addr_t a, ra, rb, tgt;
    xword_t    w, pc, pc2, av, bv;
    inst_t     inst, nxt, exp_inst;
    alu_op_e   op;
    logic [6:0] opc;
    logic [2:0] f3;
    logic [31:0] r;
    logic      taken, jalr;
    bypass_t   pe, pm, pw;
    ds_to_es_t held;

    void'($urandom(39607));
    rst_n         <= 1'b0;
    fs_valid      <= 1'b0;
    fs_bus        <= '0;
    es_allowin    <= 1'b1;
    wb            <= '0;
    es_bp         <= '0;
    ms_bp         <= '0;
    wb_bp         <= '0;
    es_load       <= 1'b0;
    ms_data_stall <= 1'b0;
    foreach (shadow[k]) shadow[k] = '0;

    e0 = n_errors;
    repeat (RST_CYC) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check("allowin after reset", 320'(ds_allowin), 320'(1'b1));
    check("valid after reset", 320'(ds_to_es_valid), 320'(1'b0));
    check("taken after reset", 320'(br_bus.taken), 320'(1'b0));
    end_test("reset", e0);

    // every register first, then random ones, x0 writes included
    e0 = n_errors;
    for (int i = 0; i < 32 + N_ITER; i++) begin
      a = (i < 32) ? gpr_addr_t'(i) : gpr_addr_t'($urandom_range(31, 0));
      w = rand_word();
      @(posedge clk);
      wb <= '{wen: 1'b1, addr: a, data: w};
      if (a != '0) shadow[a] = w;
    end
    @(posedge clk);
    wb <= '0;
    for (int i = 0; i < N_ITER; i++) begin
      ra = (i % 4 == 0) ? gpr_addr_t'(0) : rand_reg();
      rb = gpr_addr_t'($urandom_range(31, 0));
      opc = ALU_GROUPS[i % 4];
      make_alu(opc, ra, rb, gpr_addr_t'($urandom_range(31, 0)), inst, op);
      send(inst, rand_pc());
      @(negedge clk);
      check("valid", 320'(ds_to_es_valid), 320'(1'b1));
      check("rs1data", 320'(ds_out.rs1data), 320'(shadow[ra]));
      check("rs2data", 320'(ds_out.rs2data),
            320'((opc == OP_OP || opc == OP_32) ? shadow[rb] : xword_t'(0)));
      check("imm", 320'(ds_out.imm), 320'(model_imm(inst)));
      check("rd", 320'(ds_out.rd), 320'(inst[11:7]));
      check("alu_op", 320'(ds_out.ctrl.alu_op), 320'(op));
      check("gpr_wen", 320'(ds_out.ctrl.gpr_wen), 320'(inst[11:7] != 5'd0));
      check("word_cut", 320'(ds_out.ctrl.word_cut), 320'(opc == OP_32 || opc == OP_IMM_32));
    end
    end_test("regfile_decode", e0);

    e0 = n_errors;
    for (int i = 0; i < N_ITER; i++) begin
      ra = gpr_addr_t'($urandom_range(3, 0));
      rb = gpr_addr_t'($urandom_range(3, 0));
      make_alu(OP_OP, ra, rb, rand_reg(), inst, op);
      pe = rand_bp();
      pm = rand_bp();
      pw = rand_bp();
      send(inst, rand_pc());
      es_bp <= pe;
      ms_bp <= pm;
      wb_bp <= pw;
      @(negedge clk);
      check("fwd valid", 320'(ds_to_es_valid), 320'(1'b1));
      check("fwd rs1data", 320'(ds_out.rs1data), 320'(model_fwd(ra, shadow[ra], pe, pm, pw)));
      check("fwd rs2data", 320'(ds_out.rs2data), 320'(model_fwd(rb, shadow[rb], pe, pm, pw)));
    end
    @(posedge clk);
    es_bp <= '0;
    ms_bp <= '0;
    wb_bp <= '0;
    end_test("forwarding", e0);

    // 0 load-use, 1 matched memory stall, 2 unmatched memory stall
    e0 = n_errors;
    for (int i = 0; i < N_ITER; i++) begin
      kind = i % 3;
      ra   = gpr_addr_t'($urandom_range(31, 2));
      rb   = (kind == 2) ? ra : rand_reg();
      tgt  = $urandom_range(1, 0) ? ra : rb;
      make_alu(OP_OP, ra, rb, rand_reg(), inst, op);
      w    = rand_word();
      hold = $urandom_range(4, 1);
      send(inst, rand_pc());
      case (kind)
        0: begin
          es_bp   <= '{valid: 1'b1, rd: tgt, result: w};
          es_load <= 1'b1;
        end
        1: begin
          ms_bp         <= '{valid: 1'b1, rd: tgt, result: w};
          ms_data_stall <= 1'b1;
        end
        default: begin
          ms_bp         <= '{valid: 1'b1, rd: gpr_addr_t'(ra ^ 5'd1), result: w};
          ms_data_stall <= 1'b1;
        end
      endcase
      if (kind != 2) begin
        repeat (hold) begin
          @(negedge clk);
          check("stalled valid", 320'(ds_to_es_valid), 320'(1'b0));
          check("stalled allowin", 320'(ds_allowin), 320'(1'b0));
        end
        @(posedge clk);
        es_load       <= 1'b0;
        ms_data_stall <= 1'b0;
      end
      @(negedge clk);
      check("valid after stall", 320'(ds_to_es_valid), 320'(1'b1));
      if (kind == 2) begin
        check("unforwarded rs1data", 320'(ds_out.rs1data), 320'(shadow[ra]));
      end else begin
        check("stalled operand", 320'((tgt == ra) ? ds_out.rs1data : ds_out.rs2data), 320'(w));
      end
      @(posedge clk);
      es_bp         <= '0;
      ms_bp         <= '0;
      ms_data_stall <= 1'b0;
    end
    end_test("stalls", e0);

    // rs1 operand comes from execute, rs2 from memory
    e0 = n_errors;
    for (int i = 0; i < N_ITER; i++) begin
      kind = $urandom_range(3, 0);
      ra   = rand_reg();
      rb   = (ra == 5'd31) ? 5'd1 : ra + 5'd1;
      av   = rand_word();
      bv   = ($urandom_range(3, 0) == 0) ? av : rand_word();
      pc   = rand_pc();
      pc2  = rand_pc();
      r    = $urandom();
      jalr = 1'b0;
      if (kind == 2) begin
        inst  = {r[31:12], r[11:7], OP_JAL};
        taken = 1'b1;
      end else if (kind == 3) begin
        inst  = {r[31:20], ra, 3'b000, r[11:7], OP_JALR};
        taken = 1'b1;
        jalr  = 1'b1;
      end else begin
        f3 = r[14:12];
        if (f3[2:1] == 2'b01) f3[2] = 1'b1;
        inst  = {r[31:25], rb, ra, f3, r[11:7], OP_BRANCH};
        taken = model_br_cond(f3, av, bv);
      end
      make_alu(OP_OP, rand_reg(), rand_reg(), rand_reg(), nxt, op);
      send(inst, pc);
      es_bp    <= '{valid: 1'b1, rd: ra, result: av};
      ms_bp    <= '{valid: 1'b1, rd: rb, result: bv};
      fs_valid <= 1'b1;
      fs_bus   <= '{inst: nxt, pc: pc2};
      @(negedge clk);
      check("branch valid", 320'(ds_to_es_valid), 320'(1'b1));
      check("taken", 320'(br_bus.taken), 320'(taken));
      if (taken) begin
        check("target", 320'(br_bus.target),
              320'(model_target(pc, model_imm(inst), av, jalr)));
      end
      @(posedge clk);
      fs_valid <= 1'b0;
      @(negedge clk);
      exp_inst = model_latched(taken, nxt);  // nop has rd 0 and imm 0
      check("after branch valid", 320'(ds_to_es_valid), 320'(1'b1));
      check("after branch pc", 320'(ds_out.pc), 320'(pc2));
      check("after branch rd", 320'(ds_out.rd), 320'(exp_inst[11:7]));
      check("after branch imm", 320'(ds_out.imm), 320'(model_imm(exp_inst)));
      check("after branch gpr_wen", 320'(ds_out.ctrl.gpr_wen), 320'(!taken));
      check("after branch alu_op", 320'(ds_out.ctrl.alu_op), 320'(taken ? ALU_ADD : op));
    end
    @(posedge clk);
    es_bp <= '0;
    ms_bp <= '0;
    end_test("branches", e0);

    e0 = n_errors;
    for (int i = 0; i < N_ITER; i++) begin
      make_alu(OP_OP, rand_reg(), rand_reg(), rand_reg(), inst, op);
      make_alu(OP_IMM, rand_reg(), rand_reg(), rand_reg(), nxt, op);
      pc   = rand_pc();
      pc2  = rand_pc();
      hold = $urandom_range(5, 1);
      send(inst, pc);
      es_allowin <= 1'b0;
      fs_valid   <= 1'b1;
      fs_bus     <= '{inst: nxt, pc: pc2};
      @(negedge clk);
      check("latency valid", 320'(ds_to_es_valid), 320'(1'b1));
      check("latency pc", 320'(ds_out.pc), 320'(pc));
      held = ds_out;
      repeat (hold) begin
        @(negedge clk);
        check("held bus", 320'(ds_out), 320'(held));
        check("allowin under backpressure", 320'(ds_allowin), 320'(1'b0));
      end
      @(posedge clk);
      es_allowin <= 1'b1;
      @(posedge clk);
      fs_valid <= 1'b0;
      @(negedge clk);
      check("next valid", 320'(ds_to_es_valid), 320'(1'b1));
      check("next pc", 320'(ds_out.pc), 320'(pc2));
      check("next imm", 320'(ds_out.imm), 320'(model_imm(nxt)));
    end
    end_test("backpressure", e0);

    // 0 unknown opcode, 1 load, 2 store
    e0 = n_errors;
    for (int i = 0; i < N_ITER; i++) begin
      kind = i % 3;
      r    = $urandom();
      if (kind == 0) begin
        opc = 7'($urandom());
        while (opc inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH, OP_LOAD, OP_STORE,
                           OP_IMM, OP_OP, OP_IMM_32, OP_32}) begin
          opc = 7'($urandom());
        end
        inst = {r[31:7], opc};
      end else if (kind == 1) begin
        f3   = 3'($urandom_range(6, 0));
        inst = {r[31:15], f3, r[11:7], OP_LOAD};
      end else begin
        f3   = 3'($urandom_range(3, 0));
        inst = {r[31:15], f3, r[11:7], OP_STORE};
      end
      send(inst, rand_pc());
      @(negedge clk);
      check("invalid", 320'(ds_out.ctrl.invalid), 320'(kind == 0));
      check("gpr_wen", 320'(ds_out.ctrl.gpr_wen), 320'(kind == 1 && inst[11:7] != 5'd0));
      check("mem_ren", 320'(ds_out.ctrl.mem_ren), 320'(kind == 1));
      check("mem_wen", 320'(ds_out.ctrl.mem_wen), 320'(kind == 2));
      if (kind != 0) begin
        check("mem_op", 320'(ds_out.ctrl.mem_op), 320'(f3));
        check("mem imm", 320'(ds_out.imm), 320'(model_imm(inst)));
      end
    end
    end_test("invalid_mem", e0);

    $display("%0d tests, %0d with mismatches, %0d checks, %0d errors",
             n_tests, n_bad_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYC) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
    $display("Regression failed");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+.
rv_isa_pkg.sv
id_pipe_pkg.sv
ds_latch.sv
inst_decoder.sv
gpr_file.sv
operand_bypass.sv
branch_unit.sv
id_stage.sv
tb_id_stage.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_id_stage -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep "Regression passed" > /dev/null \
  && echo "simulation result: pass" \
  || { echo "simulation result: fail"; exit 1; }
